// File: sources.f
+incdir+hdl
hdl/lockstep_pkg.sv
hdl/offset_counter.sv
hdl/shadow_reset_fsm.sv
hdl/delay_line.sv
hdl/acc_core.sv
hdl/bus_intg.sv
hdl/lockstep_compare.sv
hdl/lockstep_top.sv
tests/tb_lockstep.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lockstep checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_lockstep -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_lockstep)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tests/tb_lockstep.sv
`timescale 1ns/1ps
`include "lockstep_defs.svh"

module tb_lockstep import lockstep_pkg::*; ();

  localparam int RESET_CYCLES   = 8;
  localparam int IDLE_CYCLES    = `LOCKSTEP_OFFSET + 2;
  localparam int RANDOM_CYCLES  = 200;
  localparam int FAULT_COUNT    = 5;
  localparam int FAULT_GAP      = 5;
  localparam int BAD_CODE_COUNT = 5;
  localparam int DRAIN_CYCLES   = 6;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES
                                + FAULT_COUNT * (FAULT_GAP + 1) + BAD_CODE_COUNT * 5
                                + DRAIN_CYCLES;

  logic      clk_i;
  logic      rst_ni;
  core_in_t  bus_i;
  intg_t     rdata_intg_i;
  core_out_t core_out_i;
  intg_t     wdata_intg_o;
  logic      alert_major_internal_o;
  logic      alert_major_bus_o;

  logic [31:0]               rng;
  string                     test_name;
  logic                      flip_active;
  logic [`LOCKSTEP_OFFSET:0] flip_hist;
  logic                      bus_exp;
  data_t                     model_acc;
  core_out_t                 model_out;
  int                        int_errs;
  int                        bus_errs;
  int                        intg_errs;
  int                        rst_errs;

  lockstep_top UUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .bus_i                 (bus_i),
    .rdata_intg_i          (rdata_intg_i),
    .core_out_i            (core_out_i),
    .wdata_intg_o          (wdata_intg_o),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Odd number of ones in a byte gives a zero code bit
  function automatic intg_t byte_parity_code(data_t w);
    intg_t c;
    logic  p;
    for (int b = 0; b < `INTG_W; b++) begin
      p = 1'b0;
      for (int i = 0; i < 8; i++) begin
        p = p ^ w[8*b+i];
      end
      c[b] = ~p;
    end
    return c;
  endfunction

  //////////////////////////////
  // Main core model
  //////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_acc <= '0;
      model_out <= '0;
    end else begin
      model_out.wr_en <= bus_i.rvalid;
      if (bus_i.rvalid) begin
        model_acc       <= model_acc + bus_i.rdata;
        model_out.wdata <= model_acc + bus_i.rdata;
      end
    end
  end

  // Expected alerts
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flip_hist <= '0;
      bus_exp   <= 1'b0;
    end else begin
      flip_hist <= {flip_hist[`LOCKSTEP_OFFSET-1:0], flip_active};
      bus_exp   <= bus_i.rvalid && (rdata_intg_i != byte_parity_code(bus_i.rdata));
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_internal_alert : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_internal_o == flip_hist[`LOCKSTEP_OFFSET])
    else begin
      int_errs++;
      $display("MISMATCH %s alert_major_internal_o expected %0b actual %0b", test_name,
               $sampled(flip_hist[`LOCKSTEP_OFFSET]), $sampled(alert_major_internal_o));
    end

  a_bus_alert : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_bus_o == bus_exp)
    else begin
      bus_errs++;
      $display("MISMATCH %s alert_major_bus_o expected %0b actual %0b", test_name,
               $sampled(bus_exp), $sampled(alert_major_bus_o));
    end

  a_wdata_intg : assert property (@(posedge clk_i)
    wdata_intg_o == byte_parity_code(core_out_i.wdata))
    else begin
      intg_errs++;
      $display("MISMATCH %s wdata_intg_o expected %h actual %h", test_name,
               byte_parity_code($sampled(core_out_i.wdata)), $sampled(wdata_intg_o));
    end

  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_ni |-> (!alert_major_internal_o && !alert_major_bus_o))
    else begin
      rst_errs++;
      $display("An alert was raised while rst_ni was low in %s", test_name);
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_cycle(input logic valid, input data_t data, input intg_t code,
                             input data_t flip);
    @(negedge clk_i);
    bus_i.rvalid     = valid;
    bus_i.rdata      = data;
    rdata_intg_i     = code;
    core_out_i       = model_out;
    core_out_i.wdata = model_out.wdata ^ flip;
    flip_active      = (flip != '0);
  endtask

  task automatic send_beat(input logic valid, input intg_t corrupt, input data_t flip);
    data_t data;
    rng  = next_rand(rng);
    data = rng;
    drive_cycle(valid, data, byte_parity_code(data) ^ corrupt, flip);
  endtask

  task automatic send_random(input data_t flip);
    logic valid;
    rng   = next_rand(rng);
    valid = rng[31];
    send_beat(valid, '0, flip);
  endtask

  initial begin
    intg_t corrupt;
    rst_ni       = 1'b0;
    bus_i        = '0;
    rdata_intg_i = '0;
    core_out_i   = '0;
    flip_active  = 1'b0;
    rng          = 32'h842a;
    int_errs     = 0;
    bus_errs     = 0;
    intg_errs    = 0;
    rst_errs     = 0;
    test_name    = "reset_quiet";
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (IDLE_CYCLES) drive_cycle(1'b0, '0, byte_parity_code('0), '0);

    test_name = "random_clean";
    repeat (RANDOM_CYCLES) send_random('0);

    // One flipped wdata bit per injection
    test_name = "wdata_fault";
    for (int i = 0; i < FAULT_COUNT; i++) begin
      rng = next_rand(rng);
      send_random(32'h1 << rng[20:16]);
      repeat (FAULT_GAP) send_random('0);
    end

    test_name = "bus_bad_code";
    for (int i = 0; i < BAD_CODE_COUNT; i++) begin
      rng     = next_rand(rng);
      corrupt = intg_t'(1) << rng[25:24];
      send_beat(1'b1, corrupt, '0);
      repeat (2) send_beat(1'b0, '0, '0);
      send_beat(1'b0, corrupt, '0);
      send_beat(1'b0, '0, '0);
    end

    test_name = "drain";
    repeat (DRAIN_CYCLES) drive_cycle(1'b0, '0, byte_parity_code('0), '0);

    $display("Errors: internal_alert=%0d bus_alert=%0d wdata_intg=%0d reset=%0d",
             int_errs, bus_errs, intg_errs, rst_errs);
    if (int_errs + bus_errs + intg_errs + rst_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(2 * TOTAL_CYCLES * 10);
    $display("Simulation did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: hdl/lockstep_top.sv
`timescale 1ns/1ps
`include "lockstep_defs.svh"

module lockstep_top import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  bus_i,
  input  intg_t     rdata_intg_i,
  input  core_out_t core_out_i,
  output intg_t     wdata_intg_o,
  output logic      alert_major_internal_o,
  output logic      alert_major_bus_o
);

  logic      cnt_done;
  logic      shadow_rst_n;
  logic      cmp_en;
  core_in_t  shadow_in;
  core_out_t shadow_out;
  core_out_t core_out_dly;

  //////////////////////////////
  // Reset sequencing
  //////////////////////////////

  offset_counter u_offset_counter (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .done_o(cnt_done)
  );

  shadow_reset_fsm u_shadow_reset_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .done_i       (cnt_done),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  //////////////////////////////
  // Delays and shadow core
  //////////////////////////////

  delay_line #(
    .WIDTH($bits(core_in_t)),
    .DEPTH(`LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (bus_i),
    .q_o   (shadow_in)
  );

  // One more stage to line up with the registered shadow outputs
  delay_line #(
    .WIDTH($bits(core_out_t)),
    .DEPTH(`LOCKSTEP_OFFSET + 1)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (core_out_i),
    .q_o   (core_out_dly)
  );

  acc_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(shadow_rst_n),
    .in_i  (shadow_in),
    .out_o (shadow_out)
  );

  //////////////////////////////
  // Checks
  //////////////////////////////

  bus_intg u_bus_intg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus_i       (bus_i),
    .rdata_intg_i(rdata_intg_i),
    .wdata_i     (core_out_i.wdata),
    .wdata_intg_o(wdata_intg_o),
    .intg_err_o  (alert_major_bus_o)
  );

  lockstep_compare u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmp_en_i      (cmp_en),
    .shadow_out_i  (shadow_out),
    .core_out_dly_i(core_out_dly),
    .mismatch_o    (alert_major_internal_o)
  );

endmodule

// File: hdl/lockstep_compare.sv
`timescale 1ns/1ps

module lockstep_compare import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmp_en_i,
  input  core_out_t shadow_out_i,
  input  core_out_t core_out_dly_i,
  output logic      mismatch_o
);

  core_out_t shadow_q;

  // Extra stage on the shadow side matches the longer main output delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_out_i;
    end
  end

  assign mismatch_o = cmp_en_i & (shadow_q != core_out_dly_i);

  // Both sides still hold reset values while comparison is off
  a_no_mismatch_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cmp_en_i |-> (shadow_q == core_out_dly_i));

endmodule

// File: hdl/bus_intg.sv
`timescale 1ns/1ps
`include "lockstep_defs.svh"

module bus_intg import lockstep_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  core_in_t bus_i,
  input  intg_t    rdata_intg_i,
  input  data_t    wdata_i,
  output intg_t    wdata_intg_o,
  output logic     intg_err_o
);

  // Inverted byte parity
  function automatic intg_t intg_calc(data_t data);
    intg_t code;
    for (int k = 0; k < `INTG_W; k++) begin
      code[k] = ~(^data[8*k +: 8]);
    end
    return code;
  endfunction

  //////////////////////////////
  // Read check
  //////////////////////////////

  logic  rvalid_q;
  data_t rdata_q;
  intg_t rdata_intg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q      <= bus_i.rdata;
    rdata_intg_q <= rdata_intg_i;
  end

  assign intg_err_o = rvalid_q & (intg_calc(rdata_q) != rdata_intg_q);

  // Write side code
  assign wdata_intg_o = intg_calc(wdata_i);

endmodule

// File: hdl/acc_core.sv
`timescale 1ns/1ps

module acc_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  in_i,
  output core_out_t out_o
);

  data_t     acc_q;
  data_t     acc_sum;
  core_out_t out_q;

  // Wraps at the data width
  assign acc_sum = acc_q + in_i.rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
      out_q <= '0;
    end else begin
      out_q.wr_en <= in_i.rvalid;
      if (in_i.rvalid) begin
        acc_q       <= acc_sum;
        out_q.wdata <= acc_sum;
      end
    end
  end

  // wdata holds the last sum between beats
  assign out_o = out_q;

endmodule

// File: hdl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
  parameter int unsigned WIDTH = 1,
  parameter int unsigned DEPTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [DEPTH-1:0][WIDTH-1:0] stage_q;

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

endmodule

// File: hdl/shadow_reset_fsm.sv
`timescale 1ns/1ps

module shadow_reset_fsm import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic done_i,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  rst_state_e state_q, state_d;
  logic       shadow_rst_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      HOLD: begin
        if (done_i) begin
          state_d = RUN;
        end
      end
      // Shadow runs for one cycle before outputs are compared
      RUN: begin
        state_d = CHECK;
      end
      CHECK: begin
        state_d = CHECK;
      end
      default: begin
        state_d = HOLD;
      end
    endcase
  end

  // Shadow reset comes straight from a flop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= HOLD;
      shadow_rst_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      shadow_rst_q <= (state_d != HOLD);
    end
  end

  assign shadow_rst_no = shadow_rst_q;
  assign cmp_en_o      = (state_q == CHECK);

  a_rst_before_cmp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_o) |-> $past(shadow_rst_no));

endmodule

// File: hdl/offset_counter.sv
`timescale 1ns/1ps
`include "lockstep_defs.svh"

module offset_counter (
  input  logic clk_i,
  input  logic rst_ni,
  output logic done_o
);

  localparam int unsigned CNT_W = $clog2(`LOCKSTEP_OFFSET + 1);

  logic [CNT_W-1:0] cnt_q, cnt_d;

  // Saturate at the offset
  assign cnt_d = (cnt_q == CNT_W'(`LOCKSTEP_OFFSET)) ? cnt_q : cnt_q + CNT_W'(1);

  // High from the edge that loads the final count onwards
  assign done_o = (cnt_d == CNT_W'(`LOCKSTEP_OFFSET));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  a_cnt_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CNT_W'(`LOCKSTEP_OFFSET));

endmodule

// File: hdl/lockstep_pkg.sv
package lockstep_pkg;

  `include "lockstep_defs.svh"

  //////////////////////////////
  // Bus words
  //////////////////////////////

  typedef logic [`DATA_W-1:0] data_t;

  // Bit k is the inverted XOR of byte k
  typedef logic [`INTG_W-1:0] intg_t;

  //////////////////////////////
  // Core ports
  //////////////////////////////

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } core_in_t;

  typedef struct packed {
    logic  wr_en;
    data_t wdata;
  } core_out_t;

  // Shadow reset sequencing
  typedef enum logic [1:0] {
    HOLD,
    RUN,
    CHECK
  } rst_state_e;

endpackage

// File: hdl/lockstep_defs.svh
`ifndef LOCKSTEP_DEFS_SVH
`define LOCKSTEP_DEFS_SVH

//////////////////////////////
// Lockstep timing
//////////////////////////////

// Cycles the shadow core trails the main core
`define LOCKSTEP_OFFSET 2

//////////////////////////////
// Bus widths
//////////////////////////////

// Data word on the read and write bus
`define DATA_W 32

// One integrity bit per data byte
`define INTG_W 4

`endif
